//--- vlog.f
core_pkg.sv
phase_sequencer.sv
ins_decoder.sv
reg_bank.sv
exec_unit.sv
core_top.sv
core_properties.sv
tb_core.sv

//--- Makefile
# Verilator build and run for the accumulator core

VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= sim passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_core.sv
//****************************************
// accumulator core testbench
// directed tests against a reference model
// of A, carry and R0 to R7
//****************************************
`timescale 1ns/1ns
`default_nettype none

module tb_core import core_pkg::*; ();

    localparam int clk_period  = 40;
    localparam int drive_delay = 2;
    localparam int max_cycles  = 4000;  // ~300 instructions, up to 4 cycles each

    logic              clk;
    logic              rst_n;
    logic              ins_strobe;
    logic [data_w-1:0] ins_code;
    logic [data_w-1:0] ins_imm;
    logic [data_w-1:0] acc;
    logic              cy;
    logic              busy;
    logic              done;

    int                errors;
    int                checks;
    int                cycle_cnt = 0;
    logic [31:0]       lcg_state;
    logic [data_w-1:0] m_acc;
    logic              m_cy;
    logic [data_w-1:0] m_regs [num_regs];

    core_top u_core_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .ins_strobe (ins_strobe),
        .ins_code   (ins_code),
        .ins_imm    (ins_imm),
        .acc        (acc),
        .cy         (cy),
        .busy       (busy),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    initial begin
        wait (cycle_cnt >= max_cycles);
        $display("timeout: no done after %0d cycles", max_cycles);
        $display("checks %0d, errors %0d", checks, errors);
        $display("sim failed");
        $finish;
    end

    function automatic logic [data_w-1:0] rand_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    function automatic logic [data_w-1:0] with_reg(input logic [data_w-1:0] base,
                                                   input logic [2:0] n);
        return {base[7:3], n};
    endfunction

    // step count per instruction class
    function automatic int steps_of(input logic [data_w-1:0] code);
        case (code[7:3])
            op_inc_rn[7:3], op_dec_rn[7:3]:
                return 3;
            op_add_rn[7:3], op_addc_rn[7:3], op_subb_rn[7:3], op_orl_rn[7:3],
            op_anl_rn[7:3], op_xrl_rn[7:3], op_mov_a_rn[7:3]:
                return 2;
            default:
                return 1;
        endcase
    endfunction

    task automatic check_byte(input string name, input logic [data_w-1:0] got,
                              input logic [data_w-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s is %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s is %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Error: %s is %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // two operand ops, hi is the opcode's high nibble
    task automatic alu_model(input logic [3:0] hi, input logic [data_w-1:0] opd);
        int t;
        case (hi)
            op_add_imm[7:4], op_addc_imm[7:4]: begin
                t = int'(m_acc) + int'(opd);
                if (hi == op_addc_imm[7:4])
                    t = t + int'(m_cy);
                m_cy  = (t > 255);
                m_acc = t[7:0];
            end
            op_subb_imm[7:4]: begin
                t     = int'(m_acc) - int'(opd) - int'(m_cy);
                m_cy  = (t < 0);  // borrow
                m_acc = t[7:0];
            end
            op_orl_imm[7:4]: m_acc = m_acc | opd;
            op_anl_imm[7:4]: m_acc = m_acc & opd;
            op_xrl_imm[7:4]: m_acc = m_acc ^ opd;
            default: ;
        endcase
    endtask

    task automatic model_update(input logic [data_w-1:0] code, input logic [data_w-1:0] imm);
        logic [2:0] n;
        n = code[2:0];
        if (code[3]) begin  // rn forms
            case (code[7:3])
                op_inc_rn[7:3]:     m_regs[n] = m_regs[n] + 8'd1;
                op_dec_rn[7:3]:     m_regs[n] = m_regs[n] - 8'd1;
                op_mov_rn_imm[7:3]: m_regs[n] = imm;
                op_mov_rn_a[7:3]:   m_regs[n] = m_acc;
                op_mov_a_rn[7:3]:   m_acc = m_regs[n];
                default:            alu_model(code[7:4], m_regs[n]);
            endcase
        end else if (code[2:0] == 3'b100) begin
            case (code)
                op_inc_a:     m_acc = m_acc + 8'd1;
                op_dec_a:     m_acc = m_acc - 8'd1;
                op_clr_a:     m_acc = '0;
                op_cpl_a:     m_acc = ~m_acc;
                op_mov_a_imm: m_acc = imm;
                default:      alu_model(code[7:4], imm);
            endcase
        end
    endtask

    // called and left at drive time, checks timing, acc and cy
    task automatic exec_ins(input logic [data_w-1:0] code, input logic [data_w-1:0] imm);
        int cycles;
        ins_code   = code;
        ins_imm    = imm;
        ins_strobe = 1'b1;
        cycles     = 0;
        do begin
            @(posedge clk);
            #drive_delay;
            ins_strobe = 1'b0;
            cycles++;
        end while (!done);
        model_update(code, imm);
        check_count("cycles", cycles, steps_of(code) + 1);
        check_bit("busy", busy, 1'b0);
        check_byte("acc", acc, m_acc);
        check_bit("cy", cy, m_cy);
    endtask

    task automatic test_reset_nop();
        check_byte("acc", acc, 8'h00);
        check_bit("cy", cy, 1'b0);
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        exec_ins(op_nop, rand_byte());
        exec_ins(8'hA5, rand_byte());  // undefined
    endtask

    task automatic test_reg_moves();
        for (int i = 0; i < num_regs; i++)
            exec_ins(with_reg(op_mov_rn_imm, 3'(i)), rand_byte());
        for (int i = 0; i < num_regs; i++)
            exec_ins(with_reg(op_mov_a_rn, 3'(i)), 8'h00);
        for (int i = 0; i < num_regs; i++) begin
            exec_ins(op_mov_a_imm, rand_byte());
            exec_ins(with_reg(op_mov_rn_a, 3'(i)), 8'h00);
            exec_ins(op_clr_a, 8'h00);
            exec_ins(with_reg(op_mov_a_rn, 3'(i)), 8'h00);
        end
    endtask

    task automatic test_arith();
        logic [data_w-1:0] sel;
        logic [data_w-1:0] code;
        repeat (100) begin
            sel = rand_byte();
            if (sel[6:5] == 2'b00)
                exec_ins(with_reg(op_mov_rn_imm, sel[2:0]), rand_byte());
            case (sel % 3)
                0:       code = sel[7] ? with_reg(op_add_rn, sel[2:0]) : op_add_imm;
                1:       code = sel[7] ? with_reg(op_addc_rn, sel[2:0]) : op_addc_imm;
                default: code = sel[7] ? with_reg(op_subb_rn, sel[2:0]) : op_subb_imm;
            endcase
            exec_ins(code, rand_byte());
        end
    endtask

    task automatic test_logic_unary();
        logic [data_w-1:0] sel;
        logic [data_w-1:0] code;
        exec_ins(op_mov_a_imm, 8'hFF);
        exec_ins(op_add_imm, 8'h01);  // sets cy, which must then hold
        repeat (60) begin
            sel = rand_byte();
            if (sel[6:5] == 2'b00)
                exec_ins(with_reg(op_mov_rn_imm, sel[2:0]), rand_byte());
            case (sel % 3)
                0:       code = sel[7] ? with_reg(op_orl_rn, sel[2:0]) : op_orl_imm;
                1:       code = sel[7] ? with_reg(op_anl_rn, sel[2:0]) : op_anl_imm;
                default: code = sel[7] ? with_reg(op_xrl_rn, sel[2:0]) : op_xrl_imm;
            endcase
            exec_ins(code, rand_byte());
        end
        exec_ins(op_mov_a_imm, 8'hFF);
        exec_ins(op_inc_a, 8'h00);
        check_byte("acc", acc, 8'h00);
        exec_ins(op_dec_a, 8'h00);
        check_byte("acc", acc, 8'hFF);
        exec_ins(op_cpl_a, 8'h00);
        exec_ins(op_dec_a, 8'h00);
        exec_ins(op_mov_a_imm, rand_byte());
        exec_ins(op_cpl_a, 8'h00);
        exec_ins(op_inc_a, 8'h00);
        exec_ins(op_clr_a, 8'h00);
    endtask

    task automatic test_rn_wrap();
        exec_ins(with_reg(op_mov_rn_imm, 3'd2), 8'hFF);
        exec_ins(with_reg(op_inc_rn, 3'd2), 8'h00);
        exec_ins(with_reg(op_mov_a_rn, 3'd2), 8'h00);
        check_byte("acc", acc, 8'h00);
        exec_ins(with_reg(op_dec_rn, 3'd2), 8'h00);
        exec_ins(with_reg(op_mov_a_rn, 3'd2), 8'h00);
        check_byte("acc", acc, 8'hFF);
        exec_ins(with_reg(op_mov_rn_imm, 3'd6), 8'h00);
        exec_ins(with_reg(op_dec_rn, 3'd6), 8'h00);
        exec_ins(with_reg(op_mov_a_rn, 3'd6), 8'h00);
        check_byte("acc", acc, 8'hFF);
    endtask

    task automatic test_steps_ignored();
        exec_ins(op_nop, 8'h00);
        exec_ins(with_reg(op_add_rn, 3'd1), 8'h00);
        exec_ins(with_reg(op_inc_rn, 3'd5), 8'h00);
        ins_code   = with_reg(op_inc_rn, 3'd5);
        ins_imm    = 8'h00;
        ins_strobe = 1'b1;
        @(posedge clk);
        #drive_delay;
        check_bit("busy", busy, 1'b1);
        ins_code = op_mov_a_imm;  // must be dropped
        ins_imm  = ~m_acc;
        @(posedge clk);
        #drive_delay;
        ins_strobe = 1'b0;
        while (!done) begin
            @(posedge clk);
            #drive_delay;
        end
        model_update(with_reg(op_inc_rn, 3'd5), 8'h00);
        check_byte("acc", acc, m_acc);
        @(posedge clk);
        #drive_delay;
        check_bit("busy", busy, 1'b0);
        exec_ins(with_reg(op_mov_a_rn, 3'd5), 8'h00);
    endtask

    initial begin
        rst_n      = 1'b1;
        ins_strobe = 1'b0;
        ins_code   = '0;
        ins_imm    = '0;
        errors     = 0;
        checks     = 0;
        lcg_state  = 32'd55748;
        m_acc      = '0;
        m_cy       = 1'b0;
        for (int i = 0; i < num_regs; i++)
            m_regs[i] = '0;
        #1 rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;
        test_reset_nop();
        test_reg_moves();
        test_arith();
        test_logic_unary();
        test_rn_wrap();
        test_steps_ignored();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- core_properties.sv
//****************************************
// phase sequencer properties
// done pulse, busy and ignored strobes
//****************************************
`timescale 1ns/1ns
`default_nettype none

module core_properties import core_pkg::*; (
    input logic              clk,
    input logic              rst_n,
    input logic              ins_strobe,
    input logic              busy,
    input logic              done,
    input logic [data_w-1:0] cur_code
);

    a_done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done held for more than one cycle");

    a_done_not_busy: assert property (@(posedge clk) disable iff (!rst_n) done |-> !busy)
        else $error("done while busy");

    a_idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !busy && !done)
        else $error("busy or done set after reset release");

    // strobe while busy must not load a new instruction
    a_strobe_ignored: assert property (@(posedge clk) disable iff (!rst_n)
                                       ins_strobe && busy |=> $stable(cur_code))
        else $error("cur_code changed on a strobe while busy");

endmodule

bind phase_sequencer core_properties u_core_properties (
    .clk        (clk),
    .rst_n      (rst_n),
    .ins_strobe (ins_strobe),
    .busy       (busy),
    .done       (done),
    .cur_code   (cur_code)
);

`default_nettype wire

//--- core_top.sv
//****************************************
// accumulator core top level
//****************************************
`timescale 1ns/1ns
`default_nettype none

module core_top import core_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ins_strobe,
    input  logic [data_w-1:0] ins_code,
    input  logic [data_w-1:0] ins_imm,
    output logic [data_w-1:0] acc,
    output logic              cy,
    output logic              busy,
    output logic              done
);

    logic [data_w-1:0]    cur_code;
    logic [data_w-1:0]    cur_imm;
    logic [phase_w-1:0]   phase;
    logic [phase_w-1:0]   step_count;
    step_e                step;
    alu_op_e              alu_op;
    src_e                 a_src;
    src_e                 b_src;
    logic [reg_idx_w-1:0] reg_idx;
    logic [data_w-1:0]    wr_data;
    logic [data_w-1:0]    rd_data;

    phase_sequencer u_phase_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .ins_strobe (ins_strobe),
        .ins_code   (ins_code),
        .ins_imm    (ins_imm),
        .step_count (step_count),
        .cur_code   (cur_code),
        .cur_imm    (cur_imm),
        .phase      (phase),
        .busy       (busy),
        .done       (done)
    );

    ins_decoder u_ins_decoder (
        .ins_code   (ins_code),
        .cur_code   (cur_code),
        .phase      (phase),
        .step_count (step_count),
        .step       (step),
        .alu_op     (alu_op),
        .a_src      (a_src),
        .b_src      (b_src),
        .reg_idx    (reg_idx)
    );

    reg_bank u_reg_bank (
        .clk     (clk),
        .rst_n   (rst_n),
        .step    (step),
        .reg_idx (reg_idx),
        .wr_data (wr_data),
        .rd_data (rd_data)
    );

    exec_unit u_exec_unit (
        .clk     (clk),
        .rst_n   (rst_n),
        .step    (step),
        .alu_op  (alu_op),
        .a_src   (a_src),
        .b_src   (b_src),
        .cur_imm (cur_imm),
        .rd_data (rd_data),
        .acc     (acc),
        .cy      (cy),
        .wr_data (wr_data)
    );

endmodule

`default_nettype wire

//--- exec_unit.sv
//****************************************
// execute unit
// operand mux, alu, accumulator, carry
// and ram data register
//****************************************
`timescale 1ns/1ns
`default_nettype none

module exec_unit import core_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  step_e             step,
    input  alu_op_e           alu_op,
    input  src_e              a_src,
    input  src_e              b_src,
    input  logic [data_w-1:0] cur_imm,
    input  logic [data_w-1:0] rd_data,
    output logic [data_w-1:0] acc,
    output logic              cy,
    output logic [data_w-1:0] wr_data
);

    logic [data_w-1:0] ram_data;
    logic [data_w-1:0] opa;
    logic [data_w-1:0] opb;
    logic [data_w-1:0] res;
    logic [data_w:0]   sum;
    logic              cy_nxt;

    function automatic logic [data_w-1:0] pick(input src_e s, input logic [data_w-1:0] a,
                                               input logic [data_w-1:0] r,
                                               input logic [data_w-1:0] i);
        case (s)
            src_acc:      return a;
            src_ram_data: return r;
            src_imm:      return i;
            default:      return '0;
        endcase
    endfunction

    assign opa = pick(a_src, acc, ram_data, cur_imm);
    assign opb = pick(b_src, acc, ram_data, cur_imm);

    always_comb begin
        sum    = '0;
        res    = opa;
        cy_nxt = cy;
        case (alu_op)
            alu_mov:  res = opb;
            alu_add:  sum = {1'b0, opa} + {1'b0, opb};
            alu_addc: sum = {1'b0, opa} + {1'b0, opb} + {{data_w{1'b0}}, cy};
            alu_subb: sum = {1'b0, opa} - {1'b0, opb} - {{data_w{1'b0}}, cy};
            alu_anl:  res = opa & opb;
            alu_orl:  res = opa | opb;
            alu_xrl:  res = opa ^ opb;
            alu_inc:  res = opa + 1'b1;
            alu_dec:  res = opa - 1'b1;
            alu_clr:  res = '0;
            alu_cpl:  res = ~opa;
            default:  res = opa;
        endcase
        if (alu_op inside {alu_add, alu_addc, alu_subb}) begin
            res    = sum[data_w-1:0];
            cy_nxt = sum[data_w];  // carry out, or borrow for subb
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
            cy  <= 1'b0;
        end else if (step == step_process) begin
            cy <= cy_nxt;
            if (a_src == src_acc)
                acc <= res;
        end
    end

    always_ff @(posedge clk) begin
        if (step == step_ram_read)
            ram_data <= rd_data;
        else if (step == step_process && a_src == src_ram_data)
            ram_data <= res;  // inc/dec rn result
    end

    assign wr_data = (a_src == src_acc) ? acc :
                     (a_src == src_imm) ? cur_imm : ram_data;

endmodule

`default_nettype wire

//--- reg_bank.sv
//****************************************
// register bank
// working registers R0 to R7
//****************************************
`timescale 1ns/1ns
`default_nettype none

module reg_bank import core_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  step_e                step,
    input  logic [reg_idx_w-1:0] reg_idx,
    input  logic [data_w-1:0]    wr_data,
    output logic [data_w-1:0]    rd_data
);

    logic [data_w-1:0] regs [num_regs];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++)
                regs[i] <= '0;
        end else if (step == step_ram_write) begin
            regs[reg_idx] <= wr_data;
        end
    end

    assign rd_data = regs[reg_idx];  // async read

endmodule

`default_nettype wire

//--- ins_decoder.sv
//****************************************
// instruction decoder
// maps opcode and phase to one step kind,
// alu operation and operand sources
//****************************************
`timescale 1ns/1ns
`default_nettype none

module ins_decoder import core_pkg::*; (
    input  logic [data_w-1:0]    ins_code,
    input  logic [data_w-1:0]    cur_code,
    input  logic [phase_w-1:0]   phase,
    output logic [phase_w-1:0]   step_count,
    output step_e                step,
    output alu_op_e              alu_op,
    output src_e                 a_src,
    output src_e                 b_src,
    output logic [reg_idx_w-1:0] reg_idx
);

    logic binop;  // two operand group, #data or rn form

    function automatic logic [phase_w-1:0] steps_for(input logic [data_w-1:0] code);
        logic [phase_w-1:0] n;
        casez (code)
            {op_inc_rn[7:3], 3'b???}, {op_dec_rn[7:3], 3'b???}:
                n = phase_w'(3);
            {op_add_rn[7:3], 3'b???}, {op_addc_rn[7:3], 3'b???},
            {op_orl_rn[7:3], 3'b???}, {op_anl_rn[7:3], 3'b???},
            {op_xrl_rn[7:3], 3'b???}, {op_subb_rn[7:3], 3'b???},
            {op_mov_a_rn[7:3], 3'b???}:
                n = phase_w'(2);
            default:
                n = phase_w'(1);  // undefined opcodes too
        endcase
        return n;
    endfunction

    assign step_count = steps_for(ins_code);
    assign reg_idx    = cur_code[reg_idx_w-1:0];

    always_comb begin
        step   = step_none;
        alu_op = alu_none;
        a_src  = src_none;
        b_src  = src_none;
        binop  = 1'b0;
        casez (cur_code)
            op_nop: ;
            op_inc_a, op_dec_a: begin
                step   = step_process;
                alu_op = cur_code[4] ? alu_dec : alu_inc;
                a_src  = src_acc;
            end
            {op_inc_rn[7:3], 3'b???}, {op_dec_rn[7:3], 3'b???}: begin
                alu_op = cur_code[4] ? alu_dec : alu_inc;
                a_src  = src_ram_data;
                case (phase)
                    phase_w'(3): step = step_ram_read;
                    phase_w'(2): step = step_process;
                    default:     step = step_ram_write;
                endcase
            end
            op_add_imm, op_addc_imm, {op_add_rn[7:3], 3'b???}, {op_addc_rn[7:3], 3'b???}: begin
                binop  = 1'b1;
                alu_op = cur_code[4] ? alu_addc : alu_add;
            end
            op_orl_imm, op_anl_imm, {op_orl_rn[7:3], 3'b???}, {op_anl_rn[7:3], 3'b???}: begin
                binop  = 1'b1;
                alu_op = cur_code[4] ? alu_anl : alu_orl;
            end
            op_xrl_imm, {op_xrl_rn[7:3], 3'b???}: begin
                binop  = 1'b1;
                alu_op = alu_xrl;
            end
            op_subb_imm, {op_subb_rn[7:3], 3'b???}: begin
                binop  = 1'b1;
                alu_op = alu_subb;
            end
            op_mov_a_imm, {op_mov_a_rn[7:3], 3'b???}: begin
                binop  = 1'b1;
                alu_op = alu_mov;
            end
            op_clr_a, op_cpl_a: begin
                step   = step_process;
                alu_op = cur_code[4] ? alu_cpl : alu_clr;
                a_src  = src_acc;
            end
            {op_mov_rn_imm[7:3], 3'b???}: begin
                step  = step_ram_write;
                a_src = src_imm;
            end
            {op_mov_rn_a[7:3], 3'b???}: begin
                step  = step_ram_write;
                a_src = src_acc;
            end
            default: ;  // undefined, one empty step
        endcase
        // rn forms read first, then process into A
        if (binop) begin
            a_src = src_acc;
            b_src = cur_code[3] ? src_ram_data : src_imm;
            step  = (cur_code[3] && phase == phase_w'(2)) ? step_ram_read : step_process;
        end
        if (phase == '0)
            step = step_none;  // idle
    end

endmodule

`default_nettype wire

//--- phase_sequencer.sv
//****************************************
// phase sequencer
// latches instruction and immediate,
// counts execution steps down to zero
//****************************************
`timescale 1ns/1ns
`default_nettype none

module phase_sequencer import core_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               ins_strobe,
    input  logic [data_w-1:0]  ins_code,
    input  logic [data_w-1:0]  ins_imm,
    input  logic [phase_w-1:0] step_count,
    output logic [data_w-1:0]  cur_code,
    output logic [data_w-1:0]  cur_imm,
    output logic [phase_w-1:0] phase,
    output logic               busy,
    output logic               done
);

    logic accept;

    assign accept = ins_strobe && !busy;  // strobes while busy are dropped

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_code <= op_nop;
            phase    <= '0;
            busy     <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (accept) begin
                cur_code <= ins_code;
                phase    <= step_count;
                busy     <= 1'b1;
            end else if (busy) begin
                phase <= phase - 1'b1;
                if (phase == phase_w'(1)) begin  // last step
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            cur_imm <= ins_imm;
    end

endmodule

`default_nettype wire

//--- core_pkg.sv
//****************************************
// accumulator core package
// widths, opcodes and control enums
//****************************************
`default_nettype none

package core_pkg;

    localparam int data_w    = 8;
    localparam int phase_w   = 2;  // up to three steps
    localparam int reg_idx_w = 3;
    localparam int num_regs  = 2 ** reg_idx_w;

    // 8051 encodings, rn forms give the base with n = 0
    localparam logic [data_w-1:0] op_nop        = 8'h00;
    localparam logic [data_w-1:0] op_inc_a      = 8'h04;
    localparam logic [data_w-1:0] op_inc_rn     = 8'h08;
    localparam logic [data_w-1:0] op_dec_a      = 8'h14;
    localparam logic [data_w-1:0] op_dec_rn     = 8'h18;
    localparam logic [data_w-1:0] op_add_imm    = 8'h24;
    localparam logic [data_w-1:0] op_add_rn     = 8'h28;
    localparam logic [data_w-1:0] op_addc_imm   = 8'h34;
    localparam logic [data_w-1:0] op_addc_rn    = 8'h38;
    localparam logic [data_w-1:0] op_orl_imm    = 8'h44;
    localparam logic [data_w-1:0] op_orl_rn     = 8'h48;
    localparam logic [data_w-1:0] op_anl_imm    = 8'h54;
    localparam logic [data_w-1:0] op_anl_rn     = 8'h58;
    localparam logic [data_w-1:0] op_xrl_imm    = 8'h64;
    localparam logic [data_w-1:0] op_xrl_rn     = 8'h68;
    localparam logic [data_w-1:0] op_mov_a_imm  = 8'h74;
    localparam logic [data_w-1:0] op_mov_rn_imm = 8'h78;
    localparam logic [data_w-1:0] op_subb_imm   = 8'h94;
    localparam logic [data_w-1:0] op_subb_rn    = 8'h98;
    localparam logic [data_w-1:0] op_clr_a      = 8'hE4;
    localparam logic [data_w-1:0] op_mov_a_rn   = 8'hE8;
    localparam logic [data_w-1:0] op_cpl_a      = 8'hF4;
    localparam logic [data_w-1:0] op_mov_rn_a   = 8'hF8;

    typedef enum logic [1:0] {
        step_none,
        step_ram_read,
        step_process,
        step_ram_write
    } step_e;

    typedef enum logic [3:0] {
        alu_none, alu_mov, alu_add, alu_addc, alu_subb, alu_anl,
        alu_orl, alu_xrl, alu_inc, alu_dec, alu_clr, alu_cpl
    } alu_op_e;

    // operand source, for a process step also the destination
    typedef enum logic [1:0] {
        src_acc,
        src_ram_data,
        src_imm,
        src_none
    } src_e;

endpackage

`default_nettype wire
